//--- common/com_params.svh
`ifndef COM_PARAMS_SVH
`define COM_PARAMS_SVH

// Frame geometry
`define COM_IMAGE_W 640
`define COM_IMAGE_H 480

// Register map of the memory-mapped port
`define COM_ADDR_THRESHOLD 4'd0
`define COM_ADDR_SUM_X     4'd1
`define COM_ADDR_SUM_Y     4'd2
`define COM_ADDR_MASS      4'd3
`define COM_ADDR_BB_LEFT   4'd4
`define COM_ADDR_BB_TOP    4'd5
`define COM_ADDR_BB_RIGHT  4'd6
`define COM_ADDR_BB_BOTTOM 4'd7
`define COM_ADDR_ENABLE    4'd8
`define COM_ADDR_THRESH_Y  4'd9
`define COM_ADDR_THRESH_X  4'd10

// Values after reset
`define COM_THRESHOLD_RST  8'd127
`define COM_ENABLE_RST     1'b1
`define COM_THRESH_XY_RST  11'd0

`endif

//--- common/com_pkg.sv
`default_nettype none

package com_pkg;

	// Image coordinate, wide enough for rows up to 2047 pixels
	typedef logic [10:0] coord_t;

	// One stream beat as it travels through the pipeline
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic       sop;
		logic       eop;
	} pixel_beat_t;

	// Gating controls written over the register port
	typedef struct packed {
		logic [7:0] threshold;
		logic       enable;
		coord_t     thresh_x;
		coord_t     thresh_y;
	} gate_cfg_t;

	// Per-frame sums, divided by software to get the centroid
	typedef struct packed {
		logic [31:0] sum_x;
		logic [31:0] sum_y;
		logic [31:0] mass;
	} frame_stats_t;

	typedef struct packed {
		coord_t left;
		coord_t top;
		coord_t right;
		coord_t bottom;
	} bbox_t;

endpackage

`default_nettype wire

//--- verilog/stream_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stream_reg #(
	parameter type T = logic [7:0]
) (
	input  logic clk,
	input  logic reset_n,
	input  logic valid_in,
	output logic ready_out,
	input  T     data_in,
	output logic valid_out,
	input  logic ready_in,
	output T     data_out
);

	// Take a new beat when the stage is empty or its beat leaves now
	assign ready_out = ~valid_out | ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// Payload only moves on a transfer, so a stall holds it
	always_ff @(posedge clk) begin
		if (ready_out && valid_in) begin
			data_out <= data_in;
		end
	end

endmodule

`default_nettype wire

//--- verilog/packet_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module packet_fsm (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 fire,
	input  com_pkg::pixel_beat_t beat,
	output logic                 is_video,
	output logic                 pixel_strobe,
	output logic                 frame_start,
	output logic                 frame_end
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_VIDEO,
		ST_OTHER
	} state_t;

	state_t state;
	logic   desc_video;
	logic   beat_video;

	// Descriptor type lives in the low nibble of blue
	assign desc_video = (beat.blue[3:0] == 4'h0);
	// A sop beat is judged by its own descriptor, others by the state
	assign beat_video = beat.sop ? desc_video : (state == ST_VIDEO);
	assign is_video   = (state == ST_VIDEO);

	assign frame_start  = fire & beat.sop & desc_video;
	assign pixel_strobe = fire & ~beat.sop & is_video;
	assign frame_end    = fire & beat.eop & beat_video;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else if (fire) begin
			if (beat.eop) begin
				state <= ST_IDLE;
			end else if (beat.sop) begin
				state <= desc_video ? ST_VIDEO : ST_OTHER;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/pixel_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "com_params.svh"

module pixel_counter (
	input  logic            clk,
	input  logic            reset_n,
	input  logic            frame_start,
	input  logic            pixel_strobe,
	output com_pkg::coord_t x,
	output com_pkg::coord_t y
);

	import com_pkg::*;

	localparam coord_t X_LAST = coord_t'(`COM_IMAGE_W - 1);

	// Column runs to the end of the row, then the row steps
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
		end else if (frame_start) begin
			x <= '0;
			y <= '0;
		end else if (pixel_strobe) begin
			if (x == X_LAST) begin
				x <= '0;
				y <= y + coord_t'(1);
			end else begin
				x <= x + coord_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/pixel_gate.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_gate (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 in_valid,
	input  com_pkg::pixel_beat_t in_beat,
	output logic                 out_ready,
	input  logic                 is_video,
	input  com_pkg::coord_t      x,
	input  com_pkg::coord_t      y,
	input  com_pkg::gate_cfg_t   cfg,
	output logic                 mask,
	output logic                 source_valid,
	input  logic                 source_ready,
	output com_pkg::pixel_beat_t source_beat
);

	import com_pkg::*;

	pixel_beat_t gated_beat;
	logic        pass;

	// Bright enough and inside the programmed origin
	assign pass = (in_beat.blue >= cfg.threshold) &&
		(x >= cfg.thresh_x) && (y >= cfg.thresh_y);

	// Descriptors and non-video packets keep their colour
	always_comb begin
		gated_beat = in_beat;
		if (cfg.enable && is_video && !in_beat.sop) begin
			gated_beat.red   = {8{pass}};
			gated_beat.green = {8{pass}};
			gated_beat.blue  = {8{pass}};
		end
	end

	assign mask = gated_beat.blue[0];

	stream_reg #(
		.T(pixel_beat_t)
	) out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (in_valid),
		.ready_out (out_ready),
		.data_in   (gated_beat),
		.valid_out (source_valid),
		.ready_in  (source_ready),
		.data_out  (source_beat)
	);

endmodule

`default_nettype wire

//--- centroid/centroid_accum.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_accum (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  frame_start,
	input  logic                  pixel_strobe,
	input  logic                  frame_end,
	input  logic                  mask,
	input  com_pkg::coord_t       x,
	input  com_pkg::coord_t       y,
	output com_pkg::frame_stats_t stats
);

	logic [31:0] run_x;
	logic [31:0] run_y;
	logic [31:0] run_mass;
	logic [31:0] base_x;
	logic [31:0] base_y;
	logic [31:0] base_mass;
	logic [31:0] next_x;
	logic [31:0] next_y;
	logic [31:0] next_mass;
	logic        hit;

	assign hit = pixel_strobe & mask;

	// A new frame starts from zero
	assign base_x    = frame_start ? 32'd0 : run_x;
	assign base_y    = frame_start ? 32'd0 : run_y;
	assign base_mass = frame_start ? 32'd0 : run_mass;

	assign next_x    = base_x + (hit ? 32'(x) : 32'd0);
	assign next_y    = base_y + (hit ? 32'(y) : 32'd0);
	assign next_mass = base_mass + (hit ? 32'd1 : 32'd0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run_x    <= '0;
			run_y    <= '0;
			run_mass <= '0;
			stats    <= '0;
		end else begin
			if (frame_start || hit) begin
				run_x    <= next_x;
				run_y    <= next_y;
				run_mass <= next_mass;
			end
			// Latch includes the eop pixel of this cycle
			if (frame_end) begin
				stats.sum_x <= next_x;
				stats.sum_y <= next_y;
				stats.mass  <= next_mass;
			end
		end
	end

endmodule

`default_nettype wire

//--- centroid/bbox_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "com_params.svh"

module bbox_tracker (
	input  logic            clk,
	input  logic            reset_n,
	input  logic            frame_start,
	input  logic            pixel_strobe,
	input  logic            frame_end,
	input  logic            mask,
	input  com_pkg::coord_t x,
	input  com_pkg::coord_t y,
	output com_pkg::bbox_t  box
);

	import com_pkg::*;

	localparam coord_t X_INIT = coord_t'(`COM_IMAGE_W - 1);
	localparam coord_t Y_INIT = coord_t'(`COM_IMAGE_H - 1);

	coord_t min_x, min_y, max_x, max_y;
	coord_t base_min_x, base_min_y, base_max_x, base_max_y;
	coord_t next_min_x, next_min_y, next_max_x, next_max_y;
	logic   hit;

	assign hit = pixel_strobe & mask;

	// Minimums start at the far corner, maximums at the origin
	always_comb begin
		base_min_x = frame_start ? X_INIT : min_x;
		base_min_y = frame_start ? Y_INIT : min_y;
		base_max_x = frame_start ? coord_t'(0) : max_x;
		base_max_y = frame_start ? coord_t'(0) : max_y;
		next_min_x = base_min_x;
		next_min_y = base_min_y;
		next_max_x = base_max_x;
		next_max_y = base_max_y;
		if (hit) begin
			if (x < base_min_x) next_min_x = x;
			if (y < base_min_y) next_min_y = y;
			if (x > base_max_x) next_max_x = x;
			if (y > base_max_y) next_max_y = y;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			min_x <= X_INIT;
			min_y <= Y_INIT;
			max_x <= '0;
			max_y <= '0;
			box   <= '0;
		end else begin
			min_x <= next_min_x;
			min_y <= next_min_y;
			max_x <= next_max_x;
			max_y <= next_max_y;
			if (frame_end) begin
				box.left   <= next_min_x;
				box.top    <= next_min_y;
				box.right  <= next_max_x;
				box.bottom <= next_max_y;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "com_params.svh"

module csr_regs (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  chipselect,
	input  logic                  read,
	input  logic                  write,
	input  logic [3:0]            address,
	input  logic [31:0]           writedata,
	output logic [31:0]           readdata,
	output com_pkg::gate_cfg_t    cfg,
	input  com_pkg::frame_stats_t stats,
	input  com_pkg::bbox_t        box
);

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	// Registered read data, ready the cycle after the strobe
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
		end else if (chipselect && read) begin
			case (address)
				`COM_ADDR_THRESHOLD: readdata <= 32'(cfg.threshold);
				`COM_ADDR_SUM_X:     readdata <= stats.sum_x;
				`COM_ADDR_SUM_Y:     readdata <= stats.sum_y;
				`COM_ADDR_MASS:      readdata <= stats.mass;
				`COM_ADDR_BB_LEFT:   readdata <= 32'(box.left);
				`COM_ADDR_BB_TOP:    readdata <= 32'(box.top);
				`COM_ADDR_BB_RIGHT:  readdata <= 32'(box.right);
				`COM_ADDR_BB_BOTTOM: readdata <= 32'(box.bottom);
				`COM_ADDR_ENABLE:    readdata <= 32'(cfg.enable);
				`COM_ADDR_THRESH_Y:  readdata <= 32'(cfg.thresh_y);
				`COM_ADDR_THRESH_X:  readdata <= 32'(cfg.thresh_x);
				default:             readdata <= '0;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	// Status addresses are read only
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cfg.threshold <= `COM_THRESHOLD_RST;
			cfg.enable    <= `COM_ENABLE_RST;
			cfg.thresh_x  <= `COM_THRESH_XY_RST;
			cfg.thresh_y  <= `COM_THRESH_XY_RST;
		end else if (chipselect && write) begin
			case (address)
				`COM_ADDR_THRESHOLD: cfg.threshold <= writedata[7:0];
				`COM_ADDR_ENABLE:    cfg.enable    <= writedata[0];
				`COM_ADDR_THRESH_Y:  cfg.thresh_y  <= writedata[10:0];
				`COM_ADDR_THRESH_X:  cfg.thresh_x  <= writedata[10:0];
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/com_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module com_counter_top (
	input  logic        clk,
	input  logic        reset_n,

	// Register port
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [3:0]  s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,

	// Stream sink
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	output logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,

	// Stream source
	output logic [23:0] source_data,
	output logic        source_valid,
	input  logic        source_ready,
	output logic        source_sop,
	output logic        source_eop
);

	import com_pkg::*;

	pixel_beat_t  sink_beat, in_beat, source_beat;
	gate_cfg_t    cfg;
	frame_stats_t stats;
	bbox_t        box;
	coord_t       x, y;
	logic         in_valid, out_ready, fire, mask;
	logic         is_video, pixel_strobe, frame_start, frame_end;

	assign sink_beat = '{red: sink_data[23:16], green: sink_data[15:8],
		blue: sink_data[7:0], sop: sink_sop, eop: sink_eop};
	assign source_data = {source_beat.red, source_beat.green, source_beat.blue};
	assign source_sop  = source_beat.sop;
	assign source_eop  = source_beat.eop;

	// Beat moves from the input stage to the output stage
	assign fire = in_valid & out_ready;

	stream_reg #(.T(pixel_beat_t)) in_reg (
		.clk(clk), .reset_n(reset_n),
		.valid_in(sink_valid), .ready_out(sink_ready), .data_in(sink_beat),
		.valid_out(in_valid), .ready_in(out_ready), .data_out(in_beat)
	);

	packet_fsm i_packet_fsm (
		.clk(clk), .reset_n(reset_n), .fire(fire), .beat(in_beat),
		.is_video(is_video), .pixel_strobe(pixel_strobe),
		.frame_start(frame_start), .frame_end(frame_end)
	);

	pixel_counter i_pixel_counter (
		.clk(clk), .reset_n(reset_n), .frame_start(frame_start),
		.pixel_strobe(pixel_strobe), .x(x), .y(y)
	);

	pixel_gate i_pixel_gate (
		.clk(clk), .reset_n(reset_n), .in_valid(in_valid), .in_beat(in_beat),
		.out_ready(out_ready), .is_video(is_video), .x(x), .y(y), .cfg(cfg),
		.mask(mask), .source_valid(source_valid), .source_ready(source_ready),
		.source_beat(source_beat)
	);

	centroid_accum i_centroid_accum (
		.clk(clk), .reset_n(reset_n), .frame_start(frame_start),
		.pixel_strobe(pixel_strobe), .frame_end(frame_end), .mask(mask),
		.x(x), .y(y), .stats(stats)
	);

	bbox_tracker i_bbox_tracker (
		.clk(clk), .reset_n(reset_n), .frame_start(frame_start),
		.pixel_strobe(pixel_strobe), .frame_end(frame_end), .mask(mask),
		.x(x), .y(y), .box(box)
	);

	csr_regs i_csr_regs (
		.clk(clk), .reset_n(reset_n), .chipselect(s_chipselect), .read(s_read),
		.write(s_write), .address(s_address), .writedata(s_writedata),
		.readdata(s_readdata), .cfg(cfg), .stats(stats), .box(box)
	);

endmodule

`default_nettype wire

//--- test/tb_com_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "com_params.svh"

module tb_com_counter;

	localparam int FRAMES   = 12;
	localparam int WAIT_MAX = 40000;

	logic        clk;
	logic        reset_n;
	logic        s_chipselect, s_read, s_write;
	logic [3:0]  s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;
	logic [23:0] sink_data;
	logic        sink_valid, sink_ready, sink_sop, sink_eop;
	logic [23:0] source_data;
	logic        source_valid, source_ready, source_sop, source_eop;

	// Reference copy of the gating setup
	logic [7:0]  m_threshold;
	logic        m_enable;
	logic [10:0] m_thresh_x, m_thresh_y;
	// Results the DUT should have latched
	logic [31:0] m_sum_x, m_sum_y, m_mass;
	logic [10:0] m_left, m_top, m_right, m_bottom;
	// Beats as {rgb, sop, eop}
	logic [25:0] in_q[$];
	logic [25:0] exp_q[$];

	com_counter_top i_com_counter_top (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			stop_with_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, want));
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		s_chipselect = 1'b1;
		s_write      = 1'b1;
		s_address    = addr;
		s_writedata  = data;
		@(posedge clk);
		#2;
		s_chipselect = 1'b0;
		s_write      = 1'b0;
	endtask

	// Read data is registered, so it is there one cycle after the strobe
	task automatic check_reg(input logic [3:0] addr, input logic [31:0] want,
		input string name);
		@(posedge clk);
		#2;
		s_chipselect = 1'b1;
		s_read       = 1'b1;
		s_address    = addr;
		@(posedge clk);
		#2;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		compare_value({"s_readdata ", name}, s_readdata, want);
	endtask

	task automatic configure_frame(input int f);
		logic [31:0] raw;
		if (f != 0) begin
			// Upper bits are junk and must be dropped by the register
			raw = $urandom;
			m_threshold = raw[7:0];
			write_reg(`COM_ADDR_THRESHOLD, raw);
			raw = $urandom;
			raw[10:0] = 11'($urandom_range(`COM_IMAGE_W - 1));
			m_thresh_x = raw[10:0];
			write_reg(`COM_ADDR_THRESH_X, raw);
			raw = $urandom;
			// Origin below the last row gives an empty frame
			raw[10:0] = (f == 2) ? 11'd5 : 11'($urandom_range(2));
			m_thresh_y = raw[10:0];
			write_reg(`COM_ADDR_THRESH_Y, raw);
			raw = $urandom;
			raw[0] = !(f == 3 || f == 7);
			m_enable = raw[0];
			write_reg(`COM_ADDR_ENABLE, raw);
			write_reg(`COM_ADDR_MASS, $urandom);
		end
		check_reg(`COM_ADDR_THRESHOLD, {24'd0, m_threshold}, "THRESHOLD");
		check_reg(`COM_ADDR_ENABLE, {31'd0, m_enable}, "ENABLE");
		check_reg(`COM_ADDR_THRESH_X, {21'd0, m_thresh_x}, "THRESH_X");
		check_reg(`COM_ADDR_THRESH_Y, {21'd0, m_thresh_y}, "THRESH_Y");
	endtask

	// Fills the input queue and predicts the output beats and the results
	task automatic build_frame(input bit video, input int rows);
		logic [23:0] colour, shown;
		logic [10:0] px, py, lo_x, lo_y, hi_x, hi_y;
		logic [31:0] sx, sy, cnt;
		logic        pass;
		int          npix;
		int          k;
		in_q.delete();
		exp_q.delete();
		colour = $urandom;
		colour[3:0] = video ? 4'h0 : 4'($urandom_range(15, 1));
		in_q.push_back({colour, 1'b1, 1'b0});
		exp_q.push_back({colour, 1'b1, 1'b0});
		npix = rows * `COM_IMAGE_W;
		sx = 0;
		sy = 0;
		cnt = 0;
		lo_x = `COM_IMAGE_W - 1;
		lo_y = `COM_IMAGE_H - 1;
		hi_x = 0;
		hi_y = 0;
		for (k = 0; k < npix; k++) begin
			colour = $urandom;
			px = 11'(k % `COM_IMAGE_W);
			py = 11'(k / `COM_IMAGE_W);
			pass = (colour[7:0] >= m_threshold) && (px >= m_thresh_x) && (py >= m_thresh_y);
			shown = (video && m_enable) ? {24{pass}} : colour;
			in_q.push_back({colour, 1'b0, k == npix - 1});
			exp_q.push_back({shown, 1'b0, k == npix - 1});
			if (video && shown[0]) begin
				sx = sx + px;
				sy = sy + py;
				cnt = cnt + 1;
				if (px < lo_x) lo_x = px;
				if (py < lo_y) lo_y = py;
				if (px > hi_x) hi_x = px;
				if (py > hi_y) hi_y = py;
			end
		end
		// Only video frames update what the registers report
		if (video) begin
			m_sum_x = sx;
			m_sum_y = sy;
			m_mass = cnt;
			m_left = lo_x;
			m_top = lo_y;
			m_right = hi_x;
			m_bottom = hi_y;
		end
	endtask

	// Streams one packet with random stalls on both sides
	task automatic run_frame;
		logic [25:0] beat;
		int          sent;
		int          got;
		int          cycles;
		sent = 0;
		got = 0;
		cycles = 0;
		while (got < exp_q.size()) begin
			@(posedge clk);
			if (sink_valid && sink_ready) sent++;
			if (source_valid && source_ready) begin
				compare_value("source beat", {6'd0, source_data, source_sop, source_eop},
					{6'd0, exp_q[got]});
				got++;
			end
			cycles++;
			if (cycles > WAIT_MAX) begin
				stop_with_failure("Timeout: the source stopped delivering beats");
			end
			#2;
			sink_valid = (sent < in_q.size()) && ($urandom_range(3) != 0);
			if (sent < in_q.size()) begin
				beat = in_q[sent];
				sink_data = beat[25:2];
				sink_sop = beat[1];
				sink_eop = beat[0];
			end
			source_ready = ($urandom_range(3) != 0);
		end
		sink_valid = 1'b0;
	endtask

	task automatic check_results;
		check_reg(`COM_ADDR_SUM_X, m_sum_x, "SUM_X");
		check_reg(`COM_ADDR_SUM_Y, m_sum_y, "SUM_Y");
		check_reg(`COM_ADDR_MASS, m_mass, "MASS");
		check_reg(`COM_ADDR_BB_LEFT, {21'd0, m_left}, "BB_LEFT");
		check_reg(`COM_ADDR_BB_TOP, {21'd0, m_top}, "BB_TOP");
		check_reg(`COM_ADDR_BB_RIGHT, {21'd0, m_right}, "BB_RIGHT");
		check_reg(`COM_ADDR_BB_BOTTOM, {21'd0, m_bottom}, "BB_BOTTOM");
		check_reg(4'($urandom_range(15, 11)), 32'd0, "unmapped");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int f;
		int a;
		bit video;
		void'($urandom(32'h21463610));
		reset_n = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		reset_n = 1'b1;
		m_threshold = 8'd127;
		m_enable = 1'b1;
		m_thresh_x = '0;
		m_thresh_y = '0;
		{m_sum_x, m_sum_y, m_mass} = '0;
		{m_left, m_top, m_right, m_bottom} = '0;
		for (a = 0; a < 16; a++) begin
			check_reg(4'(a), (a == 0) ? 32'd127 : (a == 8) ? 32'd1 : 32'd0, "after reset");
		end
		for (f = 0; f < FRAMES; f++) begin
			configure_frame(f);
			video = !(f == 5 || f == 9);
			build_frame(video, $urandom_range(4, 2));
			run_frame();
			check_results();
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/com_pkg.sv
verilog/stream_reg.sv
verilog/packet_fsm.sv
verilog/pixel_counter.sv
verilog/pixel_gate.sv
centroid/centroid_accum.sv
centroid/bbox_tracker.sv
verilog/csr_regs.sv
verilog/com_counter_top.sv
test/tb_com_counter.sv

//--- Bender.yml
package:
  name: com_counter

sources:
  - include_dirs:
      - common
    files:
      - common/com_pkg.sv
      - verilog/stream_reg.sv
      - verilog/packet_fsm.sv
      - verilog/pixel_counter.sv
      - verilog/pixel_gate.sv
      - centroid/centroid_accum.sv
      - centroid/bbox_tracker.sv
      - verilog/csr_regs.sv
      - verilog/com_counter_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_com_counter.sv
